// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Ready or stalled, as seen on the memory port
    typedef enum logic {
        L2_ACCESS,
        L2_BUSY
    } l2_state_t;

    // Byte offset inside a word
    localparam int ADDR_LSB = 2;

    function automatic addr_t line_index(addr_t a, int idx_bits);
        return (a >> ADDR_LSB) & ((addr_t'(1) << idx_bits) - addr_t'(1));
    endfunction

    function automatic addr_t line_tag(addr_t a, int idx_bits);
        return a >> (ADDR_LSB + idx_bits);
    endfunction

    // Rebuild the byte address of a stored line
    function automatic addr_t line_addr(addr_t tag, addr_t index, int idx_bits);
        return (tag << (ADDR_LSB + idx_bits)) | (index << ADDR_LSB);
    endfunction

endpackage

`default_nettype wire

// ==== src/coherence_pkg.sv ====
`default_nettype none

package coherence_pkg;

    // Bus transaction kinds
    // BUS_RD ends in Shared, BUS_RDX ends in Modified
    typedef enum logic [1:0] {
        BUS_RD,
        BUS_RDX,
        BUS_WB
    } bus_cmd_t;

    // MSI line state
    typedef enum logic [1:0] {
        INVALID,
        SHARED,
        MODIFIED
    } line_state_t;

endpackage

`default_nettype wire

// ==== src/l1_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_cache import mem_pkg::*, coherence_pkg::*; #(
    parameter int CACHE_WORDS = 256
) (
    input  logic     CLK,
    input  logic     nRST,
    // Processor side
    input  addr_t    addr,
    input  word_t    wdata,
    input  logic     ren,
    input  logic     wen,
    input  logic     flush,
    output word_t    rdata,
    output logic     busy,
    output logic     flush_done,
    // Bus request
    output logic     bus_req,
    output bus_cmd_t bus_cmd,
    output addr_t    bus_addr,
    output word_t    bus_wdata,
    input  logic     bus_done,
    input  word_t    bus_rdata,
    // Snoop
    input  logic     snoop_valid,
    input  addr_t    snoop_addr,
    input  bus_cmd_t snoop_cmd,
    output logic     snoop_dirty,
    output word_t    snoop_data
);

    localparam int IDX_W = $clog2(CACHE_WORDS);
    localparam int TAG_W = 32 - ADDR_LSB - IDX_W;

    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        FILL,
        UPGRADE,
        FLUSH_WALK,
        FLUSH_DONE
    } fsm_t;

    logic [TAG_W-1:0] tags   [CACHE_WORDS];
    word_t            data   [CACHE_WORDS];
    line_state_t      states [CACHE_WORDS];

    fsm_t             fsm;
    logic             flushing;
    logic [IDX_W-1:0] flush_idx;

    bus_cmd_t         req_cmd;
    addr_t            req_addr;
    word_t            req_wdata;

    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] s_idx;
    logic [IDX_W-1:0] r_idx;
    logic [TAG_W-1:0] tag;
    logic [TAG_W-1:0] s_tag;
    logic [TAG_W-1:0] r_tag;

    logic access;
    logic in_idle;
    logic hit;
    logic s_hit;
    logic wr_block;
    logic rd_done;
    logic wr_done;
    logic go_upgrade;
    logic go_wb;
    logic go_fill;
    logic walk_wb;
    logic fill_done;

    always_comb begin
        idx   = IDX_W'(line_index(addr, IDX_W));
        tag   = TAG_W'(line_tag(addr, IDX_W));
        s_idx = IDX_W'(line_index(snoop_addr, IDX_W));
        s_tag = TAG_W'(line_tag(snoop_addr, IDX_W));
        r_idx = IDX_W'(line_index(req_addr, IDX_W));
        r_tag = TAG_W'(line_tag(req_addr, IDX_W));
    end

    always_comb begin
        access  = ren || wen;
        in_idle = (fsm == IDLE) && !flush;
        hit     = (states[idx] != INVALID) && (tags[idx] == tag);
        s_hit   = (states[s_idx] != INVALID) && (tags[s_idx] == s_tag);
        // A write must not race a snoop on the same line
        wr_block = snoop_valid && (s_idx == idx);

        rd_done    = in_idle && ren && hit;
        wr_done    = in_idle && wen && hit && (states[idx] == MODIFIED) && !wr_block;
        go_upgrade = in_idle && wen && hit && (states[idx] == SHARED);
        go_wb      = in_idle && access && !hit && (states[idx] == MODIFIED);
        go_fill    = in_idle && access && !hit && (states[idx] != MODIFIED);
        walk_wb    = (fsm == FLUSH_WALK) && (states[flush_idx] == MODIFIED);
        fill_done  = ((fsm == FILL) || (fsm == UPGRADE)) && bus_done;
    end

    assign rdata      = data[idx];
    assign busy       = access && !(rd_done || wr_done);
    assign flush_done = (fsm == FLUSH_DONE);

    assign bus_req   = (fsm == WRITEBACK) || (fsm == FILL) || (fsm == UPGRADE);
    assign bus_cmd   = req_cmd;
    assign bus_addr  = req_addr;
    assign bus_wdata = req_wdata;

    assign snoop_dirty = snoop_valid && s_hit && (states[s_idx] == MODIFIED);
    assign snoop_data  = data[s_idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fsm       <= IDLE;
            flushing  <= 1'b0;
            flush_idx <= '0;
            for (int i = 0; i < CACHE_WORDS; i++) begin
                states[i] <= INVALID;
            end
        end else begin
            // Snoop side first, so the processor side wins on a shared index
            if (snoop_valid && s_hit) begin
                if (snoop_cmd == BUS_RDX) begin
                    states[s_idx] <= INVALID;
                end else if (snoop_cmd == BUS_RD && states[s_idx] == MODIFIED) begin
                    states[s_idx] <= SHARED;
                end
            end

            case (fsm)
                IDLE: begin
                    if (flush) begin
                        fsm       <= FLUSH_WALK;
                        flushing  <= 1'b1;
                        flush_idx <= '0;
                    end else if (go_upgrade) begin
                        fsm <= UPGRADE;
                    end else if (go_wb) begin
                        fsm <= WRITEBACK;
                    end else if (go_fill) begin
                        fsm <= FILL;
                    end
                end
                WRITEBACK: begin
                    if (bus_done) begin
                        states[r_idx] <= INVALID;
                        fsm <= flushing ? FLUSH_WALK : FILL;
                    end
                end
                FILL, UPGRADE: begin
                    if (bus_done) begin
                        states[r_idx] <= (req_cmd == BUS_RDX) ? MODIFIED : SHARED;
                        fsm <= IDLE;
                    end
                end
                FLUSH_WALK: begin
                    if (walk_wb) begin
                        fsm <= WRITEBACK;
                    end else begin
                        states[flush_idx] <= INVALID;
                        if (&flush_idx) begin
                            fsm <= FLUSH_DONE;
                        end else begin
                            flush_idx <= flush_idx + 1'b1;
                        end
                    end
                end
                FLUSH_DONE: begin
                    if (!flush) begin
                        fsm      <= IDLE;
                        flushing <= 1'b0;
                    end
                end
                default: fsm <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (go_wb) begin
            req_cmd   <= BUS_WB;
            req_addr  <= line_addr(addr_t'(tags[idx]), addr_t'(idx), IDX_W);
            req_wdata <= data[idx];
        end else if (walk_wb) begin
            req_cmd   <= BUS_WB;
            req_addr  <= line_addr(addr_t'(tags[flush_idx]), addr_t'(flush_idx), IDX_W);
            req_wdata <= data[flush_idx];
        end else if (go_fill || go_upgrade || (fsm == WRITEBACK && bus_done && !flushing)) begin
            req_cmd  <= wen ? BUS_RDX : BUS_RD;
            req_addr <= addr;
        end

        // Upgrades also take bus data, the line may have been invalidated meanwhile
        if (fill_done) begin
            tags[r_idx] <= r_tag;
            data[r_idx] <= bus_rdata;
        end else if (wr_done) begin
            data[idx] <= wdata;
        end
    end

    a_one_access: assert property (@(posedge CLK) disable iff (!nRST)
        !(ren && wen));

    a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        bus_req && !bus_done |=> bus_req && $stable(bus_cmd) && $stable(bus_addr)
            && $stable(bus_wdata));

    a_fill_not_dirty: assert property (@(posedge CLK) disable iff (!nRST)
        snoop_valid && (fsm == FILL)
            && (snoop_addr[31:ADDR_LSB] == req_addr[31:ADDR_LSB]) |-> !snoop_dirty);

endmodule

`default_nettype wire

// ==== src/bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl import mem_pkg::*, coherence_pkg::*; #(
    parameter int CPUS = 2
) (
    input  logic                  CLK,
    input  logic                  nRST,
    // Cache requests
    input  logic     [CPUS-1:0]   bus_req,
    input  bus_cmd_t [CPUS-1:0]   bus_cmd,
    input  addr_t    [CPUS-1:0]   bus_addr,
    input  word_t    [CPUS-1:0]   bus_wdata,
    output logic     [CPUS-1:0]   bus_done,
    output word_t                 bus_rdata,
    // Snoop
    output logic     [CPUS-1:0]   snoop_valid,
    output addr_t                 snoop_addr,
    output bus_cmd_t              snoop_cmd,
    input  logic     [CPUS-1:0]   snoop_dirty,
    input  word_t    [CPUS-1:0]   snoop_data,
    // Memory port
    output addr_t                 memory_addr,
    output word_t                 memory_wdata,
    output logic                  memory_ren,
    output logic                  memory_wen,
    input  word_t                 memory_rdata,
    input  logic                  memory_busy
);

    localparam int PTR_W = (CPUS > 1) ? $clog2(CPUS) : 1;

    typedef enum logic [2:0] {
        ARB,
        SNOOP,
        DIRTY_WB,
        MEM_READ,
        MEM_WRITE,
        DONE
    } fsm_t;

    fsm_t             fsm;
    logic [PTR_W-1:0] rr_ptr;
    logic [PTR_W-1:0] owner;
    logic [PTR_W-1:0] grant;
    logic             grant_valid;
    logic [CPUS-1:0]  owner_mask;
    logic             any_dirty;
    word_t            dirty_data;
    l2_state_t        l2_state;

    bus_cmd_t         cmd_q;
    addr_t            addr_q;
    word_t            data_q;

    assign l2_state = memory_busy ? L2_BUSY : L2_ACCESS;

    // First requester at or after the round-robin pointer
    always_comb begin
        int cand;
        grant_valid = 1'b0;
        grant       = rr_ptr;
        for (int i = 0; i < CPUS; i++) begin
            cand = (int'(rr_ptr) + i) % CPUS;
            if (!grant_valid && bus_req[cand]) begin
                grant_valid = 1'b1;
                grant       = PTR_W'(cand);
            end
        end
    end

    always_comb begin
        dirty_data = '0;
        for (int i = 0; i < CPUS; i++) begin
            if (snoop_dirty[i] && snoop_valid[i]) begin
                dirty_data = snoop_data[i];
            end
        end
    end

    assign any_dirty  = |(snoop_dirty & snoop_valid);
    assign owner_mask = CPUS'(1) << owner;

    assign snoop_valid = (fsm == SNOOP) ? ~owner_mask : '0;
    assign snoop_addr  = addr_q;
    assign snoop_cmd   = cmd_q;

    assign bus_done  = (fsm == DONE) ? owner_mask : '0;
    assign bus_rdata = data_q;

    assign memory_addr  = addr_q;
    assign memory_wdata = data_q;
    assign memory_ren   = (fsm == MEM_READ);
    assign memory_wen   = (fsm == DIRTY_WB) || (fsm == MEM_WRITE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fsm    <= ARB;
            rr_ptr <= '0;
            owner  <= '0;
        end else begin
            case (fsm)
                ARB: begin
                    if (grant_valid) begin
                        owner <= grant;
                        fsm   <= (bus_cmd[grant] == BUS_WB) ? MEM_WRITE : SNOOP;
                    end
                end
                SNOOP: fsm <= any_dirty ? DIRTY_WB : MEM_READ;
                DIRTY_WB, MEM_READ, MEM_WRITE: begin
                    if (l2_state == L2_ACCESS) begin
                        fsm <= DONE;
                    end
                end
                DONE: begin
                    rr_ptr <= (owner == PTR_W'(CPUS - 1)) ? '0 : owner + 1'b1;
                    fsm    <= ARB;
                end
                default: fsm <= ARB;
            endcase
        end
    end

    // Dirty snoop data goes to memory and to the requester
    always_ff @(posedge CLK) begin
        if (fsm == ARB && grant_valid) begin
            cmd_q  <= bus_cmd[grant];
            addr_q <= bus_addr[grant];
            data_q <= bus_wdata[grant];
        end else if (fsm == SNOOP && any_dirty) begin
            data_q <= dirty_data;
        end else if (fsm == MEM_READ && l2_state == L2_ACCESS) begin
            data_q <= memory_rdata;
        end
    end

    a_mem_one_op: assert property (@(posedge CLK) disable iff (!nRST)
        !(memory_ren && memory_wen));

    a_done_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(bus_done));

    a_single_owner: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(snoop_dirty & snoop_valid));

endmodule

`default_nettype wire

// ==== src/cache_stress_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_stress_wrapper import mem_pkg::*, coherence_pkg::*; #(
    parameter int CACHE_WORDS = 256
) (
    input  logic  CLK,
    input  logic  nRST,
    // cache0 processor port
    input  word_t cache0_addr,
    input  word_t cache0_wdata,
    input  logic  cache0_ren,
    input  logic  cache0_wen,
    input  logic  cache0_flush,
    output word_t cache0_rdata,
    output logic  cache0_busy,
    output logic  cache0_flush_done,
    // cache1 processor port
    input  word_t cache1_addr,
    input  word_t cache1_wdata,
    input  logic  cache1_ren,
    input  logic  cache1_wen,
    input  logic  cache1_flush,
    output word_t cache1_rdata,
    output logic  cache1_busy,
    output logic  cache1_flush_done,
    // Main memory
    output word_t memory_addr,
    output word_t memory_wdata,
    output logic  memory_ren,
    output logic  memory_wen,
    input  word_t memory_rdata,
    input  logic  memory_busy
);

    localparam int N_CACHES = 2;

    addr_t [N_CACHES-1:0] p_addr;
    word_t [N_CACHES-1:0] p_wdata;
    logic  [N_CACHES-1:0] p_ren;
    logic  [N_CACHES-1:0] p_wen;
    logic  [N_CACHES-1:0] p_flush;
    word_t [N_CACHES-1:0] p_rdata;
    logic  [N_CACHES-1:0] p_busy;
    logic  [N_CACHES-1:0] p_flush_done;

    logic     [N_CACHES-1:0] bus_req;
    bus_cmd_t [N_CACHES-1:0] bus_cmd;
    addr_t    [N_CACHES-1:0] bus_addr;
    word_t    [N_CACHES-1:0] bus_wdata;
    logic     [N_CACHES-1:0] bus_done;
    word_t                   bus_rdata;
    logic     [N_CACHES-1:0] snoop_valid;
    addr_t                   snoop_addr;
    bus_cmd_t                snoop_cmd;
    logic     [N_CACHES-1:0] snoop_dirty;
    word_t    [N_CACHES-1:0] snoop_data;

    // Processor inputs reach the caches one cycle late
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            p_addr  <= '0;
            p_wdata <= '0;
            p_ren   <= '0;
            p_wen   <= '0;
            p_flush <= '0;
        end else begin
            p_addr  <= {cache1_addr, cache0_addr};
            p_wdata <= {cache1_wdata, cache0_wdata};
            p_ren   <= {cache1_ren, cache0_ren};
            p_wen   <= {cache1_wen, cache0_wen};
            p_flush <= {cache1_flush, cache0_flush};
        end
    end

    assign cache0_rdata      = p_rdata[0];
    assign cache0_busy       = p_busy[0];
    assign cache0_flush_done = p_flush_done[0];
    assign cache1_rdata      = p_rdata[1];
    assign cache1_busy       = p_busy[1];
    assign cache1_flush_done = p_flush_done[1];

    for (genvar i = 0; i < N_CACHES; i++) begin : g_cache
        l1_cache #(
            .CACHE_WORDS(CACHE_WORDS)
        ) cache (
            .CLK(CLK),
            .nRST(nRST),
            .addr(p_addr[i]),
            .wdata(p_wdata[i]),
            .ren(p_ren[i]),
            .wen(p_wen[i]),
            .flush(p_flush[i]),
            .rdata(p_rdata[i]),
            .busy(p_busy[i]),
            .flush_done(p_flush_done[i]),
            .bus_req(bus_req[i]),
            .bus_cmd(bus_cmd[i]),
            .bus_addr(bus_addr[i]),
            .bus_wdata(bus_wdata[i]),
            .bus_done(bus_done[i]),
            .bus_rdata(bus_rdata),
            .snoop_valid(snoop_valid[i]),
            .snoop_addr(snoop_addr),
            .snoop_cmd(snoop_cmd),
            .snoop_dirty(snoop_dirty[i]),
            .snoop_data(snoop_data[i])
        );
    end

    bus_ctrl #(
        .CPUS(N_CACHES)
    ) bus (
        .CLK(CLK),
        .nRST(nRST),
        .bus_req(bus_req),
        .bus_cmd(bus_cmd),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_done(bus_done),
        .bus_rdata(bus_rdata),
        .snoop_valid(snoop_valid),
        .snoop_addr(snoop_addr),
        .snoop_cmd(snoop_cmd),
        .snoop_dirty(snoop_dirty),
        .snoop_data(snoop_data),
        .memory_addr(memory_addr),
        .memory_wdata(memory_wdata),
        .memory_ren(memory_ren),
        .memory_wen(memory_wen),
        .memory_rdata(memory_rdata),
        .memory_busy(memory_busy)
    );

endmodule

`default_nettype wire

// ==== verification/memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_model import mem_pkg::*; #(
    parameter int WORDS = 1024
) (
    input  logic  CLK,
    input  logic  nRST,
    input  addr_t addr,
    input  word_t wdata,
    input  logic  ren,
    input  logic  wen,
    output word_t rdata,
    output logic  busy
);

    localparam int IDX_W = $clog2(WORDS);

    word_t            mem [WORDS];
    logic [1:0]       wait_len;
    logic [1:0]       waited;
    logic [IDX_W-1:0] idx;
    logic             req;

    assign idx   = addr[ADDR_LSB +: IDX_W];
    assign req   = ren || wen;
    assign busy  = req && (waited != wait_len);
    assign rdata = mem[idx];

    // Each access is held off for wait_len cycles, redrawn after it completes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_len <= 2'd1;
            waited   <= 2'd0;
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= (addr_t'(i) << ADDR_LSB) ^ 32'hc3a5_5a3c;
            end
        end else if (req && busy) begin
            waited <= waited + 2'd1;
        end else if (req) begin
            waited   <= 2'd0;
            wait_len <= 2'($urandom % 4);
            if (wen) begin
                mem[idx] <= wdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/cache_stress_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_stress_tb import mem_pkg::*; ();

    localparam int CACHE_WORDS = 256;
    localparam int MEM_WORDS   = 4 * CACHE_WORDS;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int RAND_OPS    = 60;
    // Directed accesses, then warm-up writes and random accesses on both ports
    localparam int N_OPS       = 19 + 2 * (8 + RAND_OPS);
    localparam int CYCLE_LIMIT = N_OPS * 40 + CACHE_WORDS * 10 + 64;

    logic  CLK;
    logic  nRST;
    addr_t c_addr       [2];
    word_t c_wdata      [2];
    logic  c_ren        [2];
    logic  c_wen        [2];
    logic  c_flush      [2];
    word_t c_rdata      [2];
    logic  c_busy       [2];
    logic  c_flush_done [2];
    addr_t memory_addr;
    word_t memory_wdata;
    logic  memory_ren;
    logic  memory_wen;
    word_t memory_rdata;
    logic  memory_busy;

    // Last word written per address
    word_t model [addr_t];

    logic       rd_check [2];
    word_t      rd_exp   [2];
    word_t      rd_got   [2];
    logic       idle_check;
    logic [5:0] idle_got;
    int         errors;
    int         checks;
    int         tests;

    cache_stress_wrapper #(
        .CACHE_WORDS(CACHE_WORDS)
    ) i_cache_stress_wrapper (
        .CLK(CLK),
        .nRST(nRST),
        .cache0_addr(c_addr[0]),
        .cache0_wdata(c_wdata[0]),
        .cache0_ren(c_ren[0]),
        .cache0_wen(c_wen[0]),
        .cache0_flush(c_flush[0]),
        .cache0_rdata(c_rdata[0]),
        .cache0_busy(c_busy[0]),
        .cache0_flush_done(c_flush_done[0]),
        .cache1_addr(c_addr[1]),
        .cache1_wdata(c_wdata[1]),
        .cache1_ren(c_ren[1]),
        .cache1_wen(c_wen[1]),
        .cache1_flush(c_flush[1]),
        .cache1_rdata(c_rdata[1]),
        .cache1_busy(c_busy[1]),
        .cache1_flush_done(c_flush_done[1]),
        .memory_addr(memory_addr),
        .memory_wdata(memory_wdata),
        .memory_ren(memory_ren),
        .memory_wen(memory_wen),
        .memory_rdata(memory_rdata),
        .memory_busy(memory_busy)
    );

    memory_model #(
        .WORDS(MEM_WORDS)
    ) i_mem (
        .CLK(CLK),
        .nRST(nRST),
        .addr(memory_addr),
        .wdata(memory_wdata),
        .ren(memory_ren),
        .wen(memory_wen),
        .rdata(memory_rdata),
        .busy(memory_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    a_rdata0: assert property (@(posedge CLK) rd_check[0] |-> rd_got[0] == rd_exp[0])
        else begin
            $display("ERROR %0t cache0_rdata expected %h got %h", $time, rd_exp[0], rd_got[0]);
            errors++;
        end

    a_rdata1: assert property (@(posedge CLK) rd_check[1] |-> rd_got[1] == rd_exp[1])
        else begin
            $display("ERROR %0t cache1_rdata expected %h got %h", $time, rd_exp[1], rd_got[1]);
            errors++;
        end

    // Order is busy0, busy1, flush_done0, flush_done1, memory_ren, memory_wen
    a_idle_after_reset: assert property (@(posedge CLK) idle_check |-> idle_got == '0)
        else begin
            $display("ERROR %0t idle_outputs expected 000000 got %b", $time, idle_got);
            errors++;
        end

    a_mem_range: assert property (@(posedge CLK) disable iff (!nRST)
        (memory_ren || memory_wen) |-> memory_addr < addr_t'(MEM_WORDS * 4))
        else begin
            $display("ERROR %0t memory_addr expected below %h got %h", $time,
                MEM_WORDS * 4, memory_addr);
            errors++;
        end

    function automatic addr_t pool_addr(input int tag, input int index);
        return addr_t'((tag * CACHE_WORDS + index) << ADDR_LSB);
    endfunction

    // Inputs are registered in the DUT, so busy is first valid one edge later
    task automatic cpu_access(input int p, input bit write, input addr_t a, input word_t d);
        @(posedge CLK);
        c_addr[p]  <= a;
        c_wdata[p] <= d;
        c_ren[p]   <= !write;
        c_wen[p]   <= write;
        @(posedge CLK);
        @(negedge CLK);
        while (c_busy[p]) begin
            @(negedge CLK);
        end
        if (!write) begin
            rd_exp[p]   = model[a];
            rd_got[p]   = c_rdata[p];
            rd_check[p] = 1'b1;
            checks++;
        end
        @(posedge CLK);
        if (write) begin
            model[a] = d;
        end
        c_ren[p] <= 1'b0;
        c_wen[p] <= 1'b0;
        @(negedge CLK);
        rd_check[p] = 1'b0;
    endtask

    task automatic flush_cache(input int p);
        @(posedge CLK);
        c_flush[p] <= 1'b1;
        @(posedge CLK);
        @(negedge CLK);
        while (!c_flush_done[p]) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        c_flush[p] <= 1'b0;
        @(negedge CLK);
    endtask

    // Port p owns tags 2p and 2p+1 on indices 0 to 3
    task automatic random_traffic(input int p);
        int    slot;
        bit    write;
        addr_t a;
        for (int s = 0; s < 8; s++) begin
            cpu_access(p, 1'b1, pool_addr(2 * p + s / 4, s % 4), $urandom);
        end
        for (int n = 0; n < RAND_OPS; n++) begin
            slot  = int'($urandom % 8);
            write = 1'($urandom % 2);
            a     = pool_addr(2 * p + slot / 4, slot % 4);
            cpu_access(p, write, a, $urandom);
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests++;
        $display("%-24s %s, %0d errors", name,
            (errors == err_start) ? "passed" : "failed", errors - err_start);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Run stopped by timeout after %0d cycles", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        int    err_start;
        addr_t a;
        word_t got;
        void'($urandom(32'h042b_e34b));
        nRST       = 1'b0;
        idle_check = 1'b0;
        idle_got   = '0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        for (int p = 0; p < 2; p++) begin
            c_addr[p]   = '0;
            c_wdata[p]  = '0;
            c_ren[p]    = 1'b0;
            c_wen[p]    = 1'b0;
            c_flush[p]  = 1'b0;
            rd_check[p] = 1'b0;
            rd_exp[p]   = '0;
            rd_got[p]   = '0;
        end
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;

        err_start = errors;
        @(negedge CLK);
        idle_got   = {c_busy[0], c_busy[1], c_flush_done[0], c_flush_done[1],
                      memory_ren, memory_wen};
        idle_check = 1'b1;
        checks++;
        @(negedge CLK);
        idle_check = 1'b0;
        cpu_access(0, 1'b1, pool_addr(0, 1), 32'h1111_0001);
        cpu_access(0, 1'b0, pool_addr(0, 1), '0);
        cpu_access(1, 1'b1, pool_addr(0, 2), 32'h2222_0002);
        cpu_access(1, 1'b0, pool_addr(0, 2), '0);
        finish_test("same-cache consistency", err_start);

        err_start = errors;
        a = pool_addr(1, 8);
        cpu_access(0, 1'b1, a, 32'hd1e7_0008);
        cpu_access(1, 1'b0, a, '0);
        cpu_access(0, 1'b0, a, '0);
        finish_test("dirty sharing", err_start);

        // cache1 still holds this line Modified from the first test
        err_start = errors;
        a = pool_addr(0, 2);
        cpu_access(0, 1'b0, a, '0);
        cpu_access(1, 1'b0, a, '0);
        cpu_access(1, 1'b1, a, 32'h3c3c_0002);
        cpu_access(0, 1'b0, a, '0);
        finish_test("invalidation on write", err_start);

        err_start = errors;
        for (int t = 0; t < 4; t++) begin
            cpu_access(0, 1'b1, pool_addr(t, 5), 32'he000_0050 + word_t'(t));
        end
        for (int t = 0; t < 4; t++) begin
            cpu_access(0, 1'b0, pool_addr(t, 5), '0);
        end
        finish_test("eviction write-back", err_start);

        err_start = errors;
        fork
            flush_cache(0);
            flush_cache(1);
        join
        repeat (2) @(posedge CLK);
        foreach (model[k]) begin
            got = i_mem.mem[k[ADDR_LSB +: MEM_IDX_W]];
            checks++;
            assert (got == model[k]) else begin
                $display("ERROR %0t memory word %h expected %h got %h", $time, k, model[k], got);
                errors++;
            end
        end
        finish_test("flush", err_start);

        err_start = errors;
        fork
            random_traffic(0);
            random_traffic(1);
        join
        finish_test("random stress", err_start);

        repeat (2) @(posedge CLK);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/mem_pkg.sv
src/coherence_pkg.sv
src/l1_cache.sv
src/bus_ctrl.sv
src/cache_stress_wrapper.sv
verification/memory_model.sv
verification/cache_stress_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module cache_stress_tb -f compile.f \
    && ./obj_dir/Vcache_stress_tb | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
